// ==== axil_noc_bridge.f ====
hdl/noc_bridge_pkg.sv
hdl/sync_fifo.sv
hdl/axil_request_capture.sv
hdl/strobe_to_size.sv
hdl/noc_request_serializer.sv
hdl/axil_noc_bridge.sv
sim/axil_noc_bridge_properties.sv
sim/axil_noc_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f axil_noc_bridge.f \
    --top-module axil_noc_bridge_tb -o axil_noc_bridge_sim

output=$(./obj_dir/axil_noc_bridge_sim)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// ==== sim/axil_noc_bridge_tb.sv ====
`timescale 1ns/1ps

module axil_noc_bridge_tb;

    localparam int TIMEOUT_CYCLES = 3000;   // all six tests need well under 1000
    localparam int READY_ALWAYS = 0;
    localparam int READY_HOLD   = 1;
    localparam int READY_RANDOM = 2;

    typedef struct packed {
        logic        is_store;
        logic [39:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
    } axi_req_t;

    logic                      clk;
    logic                      rst;
    logic [39:0]               awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [63:0]               wdata;
    logic [7:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [39:0]               araddr;
    logic                      arvalid;
    logic                      arready;
    noc_bridge_pkg::noc_node_t src_node;
    noc_bridge_pkg::noc_node_t dest_node;
    logic                      noc2_valid;
    noc_bridge_pkg::noc_flit_u noc2_data;
    logic                      noc2_ready;

    logic [63:0] exp_flits[$];
    logic [63:0] exp_flit;
    logic [31:0] coin;
    int          ready_mode;
    int          cycle_count;
    int          mismatch_count;
    int          flow_errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;

    axil_noc_bridge u_axil_noc_bridge (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, flits still missing", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // noc2 back-pressure
    initial begin
        noc2_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            coin = $urandom();
            case (ready_mode)
                READY_HOLD:   noc2_ready = 1'b0;
                READY_RANDOM: noc2_ready = coin[0];
                default:      noc2_ready = 1'b1;
            endcase
        end
    end

    // expected flit sequence of one request
    function automatic void expand_request(input axi_req_t r);
        int         n;
        int         lo;
        logic [7:0] run;
        logic [2:0] size;
        logic [2:0] off;
        n    = $countones(r.strb);
        lo   = 0;
        size = noc_bridge_pkg::DATA_SIZE_8B;
        off  = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (r.strb[i]) lo = i;
        end
        run = 8'(((1 << n) - 1) << lo);
        if (n != 0 && r.strb == run && (lo % n) == 0) begin
            off = 3'(lo);
            case (n)
                1:       size = noc_bridge_pkg::DATA_SIZE_1B;
                2:       size = noc_bridge_pkg::DATA_SIZE_2B;
                4:       size = noc_bridge_pkg::DATA_SIZE_4B;
                default: off = 3'd0;   // sent as 8B, no offset
            endcase
        end
        if (r.is_store) begin
            exp_flits.push_back({dest_node, 8'd3, 8'd15, 8'd0, 6'd0});
            exp_flits.push_back({8'd0, r.addr[39:3], off, 13'd0, size});
            exp_flits.push_back({src_node, 30'd0});
            exp_flits.push_back(r.data);
        end else begin
            exp_flits.push_back({dest_node, 8'd2, 8'd14, 8'd0, 6'd0});
            exp_flits.push_back({8'd0, r.addr, 13'd0, noc_bridge_pkg::DATA_SIZE_8B});
            exp_flits.push_back({src_node, 30'd0});
        end
    endfunction

    // flit check and request capture, both at negedge where signals are settled
    always @(negedge clk) begin
        if (!rst && noc2_valid && noc2_ready) begin
            if (exp_flits.size() == 0) begin
                $display("unexpected flit %h with no request pending", noc2_data.data);
                mismatch_count = mismatch_count + 1;
            end else begin
                exp_flit = exp_flits.pop_front();
                if (noc2_data.data !== exp_flit) begin
                    $display("Mismatch noc2_data: expected %h, got %h", exp_flit,
                             noc2_data.data);
                    mismatch_count = mismatch_count + 1;
                end
            end
        end
        if (!rst && awvalid && wvalid && awready) begin
            if (wready !== 1'b1) begin
                $display("Mismatch wready: expected %h, got %h", 1'b1, wready);
                mismatch_count = mismatch_count + 1;
            end
            expand_request('{is_store: 1'b1, addr: awaddr, data: wdata, strb: wstrb});
        end
        if (!rst && arvalid && arready) begin
            expand_request('{is_store: 1'b0, addr: araddr, data: 64'd0, strb: 8'd0});
        end
    end

    function automatic logic [39:0] random_addr();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[39:0];
    endfunction

    function automatic logic [63:0] random_data();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [7:0] random_aligned_strobe(input int nbytes);
        int off;
        off = int'($urandom() % (8 / nbytes)) * nbytes;
        return 8'(((1 << nbytes) - 1) << off);
    endfunction

    // all issue tasks start and end 2 ns after a rising edge
    task automatic issue_write(input logic [39:0] addr, input logic [63:0] data,
                               input logic [7:0] strb);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic issue_read(input logic [39:0] addr);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
    endtask

    task automatic issue_write_and_read(input logic [39:0] waddr, input logic [63:0] data,
                                        input logic [39:0] raddr);
        awaddr  = waddr;
        wdata   = data;
        wstrb   = 8'hff;
        araddr  = raddr;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        arvalid = 1'b1;
        @(negedge clk);
        if (!awready || arready) begin   // queues are empty here
            $display("the write was not taken ahead of the simultaneous read");
            flow_errors = flow_errors + 1;
        end
        while (!awready) @(negedge clk);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (exp_flits.size() != 0) @(negedge clk);
        @(posedge clk);
        #2;
        if (noc2_valid) begin
            $display("noc2_valid still high after the last expected flit");
            flow_errors = flow_errors + 1;
        end
    endtask

    task automatic begin_test();
        test_start_errors = mismatch_count + flow_errors;
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (mismatch_count + flow_errors == test_start_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed", tests_run, name);
        end
    endtask

    initial begin
        void'($urandom(72781));
        rst            = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        src_node       = '{chipid: 14'h0012, x: 8'h03, y: 8'h05, fbits: 4'h0};
        dest_node      = '{chipid: 14'h0007, x: 8'h01, y: 8'h02, fbits: 4'ha};
        ready_mode     = READY_ALWAYS;
        cycle_count    = 0;
        mismatch_count = 0;
        flow_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        begin_test();
        issue_read(random_addr());
        wait_drain();
        finish_test("single read");

        begin_test();
        issue_write(random_addr(), random_data(), 8'hff);
        wait_drain();
        finish_test("single full write");

        begin_test();
        for (int k = 0; k < 6; k++) begin
            issue_write(random_addr(), random_data(), random_aligned_strobe(1 << (k % 3)));
        end
        wait_drain();
        finish_test("partial strobes");

        begin_test();
        ready_mode = READY_HOLD;
        for (int k = 0; k < 8; k++) begin
            if ($urandom() % 2 == 0) begin
                issue_write(random_addr(), random_data(), random_aligned_strobe(1 << (k % 4)));
            end else begin
                issue_read(random_addr());
            end
        end
        ready_mode = READY_RANDOM;   // drain under random back-pressure
        wait_drain();
        ready_mode = READY_ALWAYS;
        finish_test("mixed burst with back-pressure");

        begin_test();
        issue_write_and_read(random_addr(), random_data(), random_addr());
        wait_drain();
        finish_test("write priority");

        begin_test();
        issue_write(random_addr(), random_data(), 8'h5a);
        issue_write(random_addr(), random_data(), 8'h06);   // contiguous but misaligned
        wait_drain();
        finish_test("non-contiguous strobe");

        $display("tests run %0d, failed %0d, mismatches %0d, other errors %0d",
                 tests_run, tests_failed, mismatch_count, flow_errors);
        if (tests_failed == 0 && mismatch_count == 0 && flow_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/axil_noc_bridge_properties.sv ====
`timescale 1ns/1ps

module axil_noc_bridge_properties (
    input logic                                      clk,
    input logic                                      rst,
    input logic                                      awvalid,
    input logic                                      wvalid,
    input logic                                      awready,
    input logic                                      arready,
    input logic                                      noc2_valid,
    input logic [noc_bridge_pkg::NOC_DATA_WIDTH-1:0] noc2_data,
    input logic                                      noc2_ready
);

    // stalled flit must hold
    flit_held: assert property (@(posedge clk) disable iff (rst)
        (noc2_valid && !noc2_ready) |=> (noc2_valid && $stable(noc2_data)))
        else $error("noc2 flit changed while noc2_ready was low");

    write_priority: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> !arready)
        else $error("arready high while awvalid high");

    awready_needs_both: assert property (@(posedge clk) disable iff (rst)
        awready |-> (awvalid && wvalid))
        else $error("awready high without awvalid and wvalid");

endmodule

bind axil_noc_bridge axil_noc_bridge_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .awready    (awready),
    .arready    (arready),
    .noc2_valid (noc2_valid),
    .noc2_data  (noc2_data),
    .noc2_ready (noc2_ready)
);

// ==== hdl/axil_noc_bridge.sv ====
`timescale 1ns/1ps

module axil_noc_bridge (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  logic [noc_bridge_pkg::NOC_DATA_WIDTH-1:0] wdata,
    input  logic [noc_bridge_pkg::AXI_STRB_WIDTH-1:0] wstrb,
    input  logic                                      wvalid,
    output logic                                      wready,
    input  logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                      arvalid,
    output logic                                      arready,

    input  noc_bridge_pkg::noc_node_t                 src_node,
    input  noc_bridge_pkg::noc_node_t                 dest_node,

    output logic                                      noc2_valid,
    output noc_bridge_pkg::noc_flit_u                 noc2_data,
    input  logic                                      noc2_ready
);

    noc_bridge_pkg::req_kind_t                 order_head;
    logic                                      order_empty;
    logic                                      order_pop;
    noc_bridge_pkg::write_entry_t              write_head;
    logic                                      write_empty;
    logic                                      write_pop;
    logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] read_head;
    logic                                      read_empty;
    logic                                      read_pop;
    logic [noc_bridge_pkg::AXI_STRB_WIDTH-1:0] strobe;
    logic                                      strobe_load;
    logic [2:0]                                data_size;
    logic [2:0]                                offset;

    axil_request_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .order_head  (order_head),
        .order_empty (order_empty),
        .order_pop   (order_pop),
        .write_head  (write_head),
        .write_empty (write_empty),
        .write_pop   (write_pop),
        .read_head   (read_head),
        .read_empty  (read_empty),
        .read_pop    (read_pop)
    );

    strobe_to_size u_strobe_to_size (
        .clk       (clk),
        .rst       (rst),
        .strobe    (strobe),
        .load      (strobe_load),
        .data_size (data_size),
        .offset    (offset)
    );

    noc_request_serializer u_serializer (
        .clk         (clk),
        .rst         (rst),
        .src_node    (src_node),
        .dest_node   (dest_node),
        .order_head  (order_head),
        .order_empty (order_empty),
        .write_head  (write_head),
        .write_empty (write_empty),
        .read_head   (read_head),
        .read_empty  (read_empty),
        .order_pop   (order_pop),
        .write_pop   (write_pop),
        .read_pop    (read_pop),
        .strobe      (strobe),
        .strobe_load (strobe_load),
        .data_size   (data_size),
        .offset      (offset),
        .noc2_valid  (noc2_valid),
        .noc2_data   (noc2_data),
        .noc2_ready  (noc2_ready)
    );

endmodule

// ==== hdl/noc_request_serializer.sv ====
`timescale 1ns/1ps

module noc_request_serializer (
    input  logic                                      clk,
    input  logic                                      rst,

    input  noc_bridge_pkg::noc_node_t                 src_node,
    input  noc_bridge_pkg::noc_node_t                 dest_node,

    input  noc_bridge_pkg::req_kind_t                 order_head,
    input  logic                                      order_empty,
    input  noc_bridge_pkg::write_entry_t              write_head,
    input  logic                                      write_empty,
    input  logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] read_head,
    input  logic                                      read_empty,
    output logic                                      order_pop,
    output logic                                      write_pop,
    output logic                                      read_pop,

    output logic [noc_bridge_pkg::AXI_STRB_WIDTH-1:0] strobe,
    output logic                                      strobe_load,
    input  logic [2:0]                                data_size,
    input  logic [2:0]                                offset,

    output logic                                      noc2_valid,
    output noc_bridge_pkg::noc_flit_u                 noc2_data,
    input  logic                                      noc2_ready
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SIZE,
        ST_HDR1,
        ST_HDR2,
        ST_HDR3,
        ST_DATA
    } state_t;

    state_t state;
    logic   is_store;
    logic   start;
    logic   last_flit;

    assign is_store = (order_head == noc_bridge_pkg::REQ_STORE);
    assign start    = !order_empty && (is_store ? !write_empty : !read_empty);

    // final flit accepted: hdr3 of a load or the data flit of a store
    assign last_flit = noc2_ready &&
                       ((state == ST_HDR3 && !is_store) || state == ST_DATA);

    assign order_pop = last_flit;
    assign write_pop = last_flit && is_store;
    assign read_pop  = last_flit && !is_store;

    assign strobe      = write_head.strb;
    assign strobe_load = (state == ST_SIZE);   // size/offset ready by hdr1

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) state <= is_store ? ST_SIZE : ST_HDR1;
                end
                ST_SIZE: state <= ST_HDR1;
                ST_HDR1: begin
                    if (noc2_ready) state <= ST_HDR2;
                end
                ST_HDR2: begin
                    if (noc2_ready) state <= ST_HDR3;
                end
                ST_HDR3: begin
                    if (noc2_ready) state <= is_store ? ST_DATA : ST_IDLE;
                end
                ST_DATA: begin
                    if (noc2_ready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign noc2_valid = (state == ST_HDR1) || (state == ST_HDR2) ||
                        (state == ST_HDR3) || (state == ST_DATA);

    // everything here comes from state and queue heads, so it holds under stall
    always_comb begin
        noc2_data = '0;   // option fields and mshrid stay zero
        case (state)
            ST_HDR1: begin
                noc2_data.hdr1.dst      = dest_node;
                noc2_data.hdr1.length   = is_store ? noc_bridge_pkg::STORE_MSG_LENGTH
                                                   : noc_bridge_pkg::LOAD_MSG_LENGTH;
                noc2_data.hdr1.msg_type = is_store ? noc_bridge_pkg::MSG_TYPE_NC_STORE_REQ
                                                   : noc_bridge_pkg::MSG_TYPE_NC_LOAD_REQ;
            end
            ST_HDR2: begin
                if (is_store) begin
                    // byte offset goes into the low address bits
                    noc2_data.hdr2.addr = {
                        {(noc_bridge_pkg::MSG_ADDR_WIDTH - noc_bridge_pkg::AXI_ADDR_WIDTH){1'b0}},
                        write_head.addr[noc_bridge_pkg::AXI_ADDR_WIDTH-1:3],
                        offset
                    };
                    noc2_data.hdr2.data_size = data_size;
                end else begin
                    noc2_data.hdr2.addr = {
                        {(noc_bridge_pkg::MSG_ADDR_WIDTH - noc_bridge_pkg::AXI_ADDR_WIDTH){1'b0}},
                        read_head
                    };
                    noc2_data.hdr2.data_size = noc_bridge_pkg::DATA_SIZE_8B;
                end
            end
            ST_HDR3: noc2_data.hdr3.src = src_node;
            ST_DATA: noc2_data.data = write_head.data;
            default: noc2_data = '0;
        endcase
    end

endmodule

// ==== hdl/strobe_to_size.sv ====
`timescale 1ns/1ps

module strobe_to_size (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [noc_bridge_pkg::AXI_STRB_WIDTH-1:0] strobe,
    input  logic                                      load,
    output logic [2:0]                                data_size,
    output logic [2:0]                                offset
);

    logic [2:0] size_dec;
    logic [2:0] offset_dec;

    // only aligned runs of 1, 2, 4 or 8 bytes map to a real size
    always_comb begin
        size_dec   = noc_bridge_pkg::DATA_SIZE_8B;   // full or odd strobe
        offset_dec = 3'd0;
        for (int i = 0; i < noc_bridge_pkg::AXI_STRB_WIDTH; i++) begin
            if (strobe == (8'h01 << i)) begin
                size_dec   = noc_bridge_pkg::DATA_SIZE_1B;
                offset_dec = 3'(i);
            end
            if ((i % 2 == 0) && (strobe == (8'h03 << i))) begin
                size_dec   = noc_bridge_pkg::DATA_SIZE_2B;
                offset_dec = 3'(i);
            end
            if ((i % 4 == 0) && (strobe == (8'h0f << i))) begin
                size_dec   = noc_bridge_pkg::DATA_SIZE_4B;
                offset_dec = 3'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_size <= noc_bridge_pkg::DATA_SIZE_8B;
            offset    <= 3'd0;
        end else if (load) begin
            data_size <= size_dec;
            offset    <= offset_dec;
        end
    end

endmodule

// ==== hdl/axil_request_capture.sv ====
`timescale 1ns/1ps

module axil_request_capture (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                                      awvalid,
    output logic                                      awready,
    input  logic [noc_bridge_pkg::NOC_DATA_WIDTH-1:0] wdata,
    input  logic [noc_bridge_pkg::AXI_STRB_WIDTH-1:0] wstrb,
    input  logic                                      wvalid,
    output logic                                      wready,
    input  logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                                      arvalid,
    output logic                                      arready,

    output noc_bridge_pkg::req_kind_t                 order_head,
    output logic                                      order_empty,
    input  logic                                      order_pop,
    output noc_bridge_pkg::write_entry_t              write_head,
    output logic                                      write_empty,
    input  logic                                      write_pop,
    output logic [noc_bridge_pkg::AXI_ADDR_WIDTH-1:0] read_head,
    output logic                                      read_empty,
    input  logic                                      read_pop
);

    logic                                order_full;
    logic                                write_full;
    logic                                read_full;
    logic                                write_accept;
    logic                                read_accept;
    logic [0:0]                          order_head_bits;
    noc_bridge_pkg::req_kind_t           order_kind;
    noc_bridge_pkg::write_entry_t        write_entry;

    // write needs address and data together, and wins over a read
    assign awready = awvalid && wvalid && !order_full && !write_full;
    assign wready  = awready;
    assign arready = !awvalid && !order_full && !read_full;

    assign write_accept = awvalid && wvalid && awready;
    assign read_accept  = arvalid && arready;

    assign order_kind  = write_accept ? noc_bridge_pkg::REQ_STORE : noc_bridge_pkg::REQ_LOAD;
    assign write_entry = '{addr: awaddr, data: wdata, strb: wstrb};
    assign order_head  = noc_bridge_pkg::req_kind_t'(order_head_bits);

    // arrival order of loads and stores
    sync_fifo #(
        .WIDTH(1),
        .DEPTH(noc_bridge_pkg::FIFO_DEPTH)
    ) order_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (write_accept || read_accept),
        .push_data (order_kind),
        .pop       (order_pop),
        .head      (order_head_bits),
        .empty     (order_empty),
        .full      (order_full)
    );

    sync_fifo #(
        .WIDTH($bits(noc_bridge_pkg::write_entry_t)),
        .DEPTH(noc_bridge_pkg::FIFO_DEPTH)
    ) write_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (write_accept),
        .push_data (write_entry),
        .pop       (write_pop),
        .head      (write_head),
        .empty     (write_empty),
        .full      (write_full)
    );

    sync_fifo #(
        .WIDTH(noc_bridge_pkg::AXI_ADDR_WIDTH),
        .DEPTH(noc_bridge_pkg::FIFO_DEPTH)
    ) read_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (read_accept),
        .push_data (araddr),
        .pop       (read_pop),
        .head      (read_head),
        .empty     (read_empty),
        .full      (read_full)
    );

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16      // must be a power of two
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];                // oldest entry
    assign empty = (count == '0);
    assign full  = count[$clog2(DEPTH)];      // top bit set only at DEPTH

endmodule

// ==== hdl/noc_bridge_pkg.sv ====
package noc_bridge_pkg;

    localparam int NOC_DATA_WIDTH = 64;
    localparam int AXI_ADDR_WIDTH = 40;
    localparam int AXI_STRB_WIDTH = 8;
    localparam int MSG_ADDR_WIDTH = 48;
    localparam int FIFO_DEPTH     = 16;   // power of two

    localparam logic [7:0] MSG_TYPE_NC_LOAD_REQ  = 8'd14;
    localparam logic [7:0] MSG_TYPE_NC_STORE_REQ = 8'd15;

    // flits following header 1
    localparam logic [7:0] LOAD_MSG_LENGTH  = 8'd2;
    localparam logic [7:0] STORE_MSG_LENGTH = 8'd3;

    localparam logic [2:0] DATA_SIZE_1B = 3'd1;
    localparam logic [2:0] DATA_SIZE_2B = 3'd2;
    localparam logic [2:0] DATA_SIZE_4B = 3'd3;
    localparam logic [2:0] DATA_SIZE_8B = 3'd4;

    typedef struct packed {
        logic [13:0] chipid;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [3:0]  fbits;
    } noc_node_t;

    typedef enum logic {
        REQ_LOAD  = 1'b0,
        REQ_STORE = 1'b1
    } req_kind_t;

    typedef struct packed {
        noc_node_t   dst;
        logic [7:0]  length;
        logic [7:0]  msg_type;
        logic [7:0]  mshrid;
        logic [5:0]  options_1;
    } noc_hdr1_t;

    typedef struct packed {
        logic [MSG_ADDR_WIDTH-1:0] addr;
        logic [12:0]               options_2;
        logic [2:0]                data_size;
    } noc_hdr2_t;

    typedef struct packed {
        noc_node_t   src;
        logic [29:0] options_3;
    } noc_hdr3_t;

    // one flit on the wire, meaning depends on its position in the message
    typedef union packed {
        noc_hdr1_t                 hdr1;
        noc_hdr2_t                 hdr2;
        noc_hdr3_t                 hdr3;
        logic [NOC_DATA_WIDTH-1:0] data;
    } noc_flit_u;

    typedef struct packed {
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [NOC_DATA_WIDTH-1:0] data;
        logic [AXI_STRB_WIDTH-1:0] strb;
    } write_entry_t;

endpackage
